//--- list.f
+incdir+.
audio_pkg.sv
audio_mixer.sv
sample_fifo.sv
sample_sender.sv
audio_top.sv
tb_audio_top.sv

//--- Makefile
# Verilator build and run of the audio path testbench
# Any variable below can be overridden, e.g. make test LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_audio_top
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

FAIL_MSG  := TEST RESULT: FAIL
PASS_MSG  := TEST RESULT: PASS
SIM       := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	-$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation gave no result, see $(LOG)"; exit 1; \
	else \
		echo "Simulation passed"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb_audio_top.sv
// Directed testbench for audio_top with a req/ack sink that has a random ack delay
// Expected samples come from a model of the card mix rule and are checked in tick order

`include "audio_defs.svh"

module tb_audio_top;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD = 10;
    localparam int SEED_INIT  = 28732;
    localparam int RAND_TICKS = 20;
    localparam int KEPT_TICKS = `FIFO_DEPTH + 1;     // Mixer register plus full FIFO
    localparam int OVF_TICKS  = `FIFO_DEPTH + 3;
    // Rough cycles per test, the watchdog allows twice the sum
    localparam int TEST_CYCLES = 40 + 80 + 80 + RAND_TICKS * 14 + 200 + 40;

    logic                  a2bus_if;
    logic                  rst_n_i;
    logic                  sample_tick_i;
    audio_pkg::sample_t    synth_l_i;
    audio_pkg::sample_t    synth_r_i;
    logic [`SRC_WIDTH-1:0] card_l_i;
    logic [`SRC_WIDTH-1:0] card_r_i;
    logic [`SRC_WIDTH-1:0] sprite_i;
    logic                  speaker_i;
    logic                  speaker_en_i;
    audio_pkg::sample_t    out_l_o;
    audio_pkg::sample_t    out_r_o;
    logic                  out_req_o;
    logic                  out_ack_i;
    logic                  overflow_o;

    int  seed;
    int  mismatch_cnt;
    int  fail_cnt;
    bit  hold_ack;       // Sink keeps ack low while set
    int  max_ack_delay;  // Upper bound of the sink's random delay in cycles

    audio_pkg::sample_t exp_l[$];
    audio_pkg::sample_t exp_r[$];
    audio_pkg::sample_t rx_l[$];
    audio_pkg::sample_t rx_r[$];

    audio_top i_audio_top (
        .a2bus_if      (a2bus_if),
        .rst_n_i       (rst_n_i),
        .sample_tick_i (sample_tick_i),
        .synth_l_i     (synth_l_i),
        .synth_r_i     (synth_r_i),
        .card_l_i      (card_l_i),
        .card_r_i      (card_r_i),
        .sprite_i      (sprite_i),
        .speaker_i     (speaker_i),
        .speaker_en_i  (speaker_en_i),
        .out_l_o       (out_l_o),
        .out_r_o       (out_r_o),
        .out_req_o     (out_req_o),
        .out_ack_i     (out_ack_i),
        .overflow_o    (overflow_o)
    );

    initial begin
        a2bus_if = 1'b0;
        forever #(CLK_PERIOD / 2) a2bus_if = ~a2bus_if;
    end

    // Card mix rule: 10-bit sources up by 3, speaker worth 4096, wrap modulo 2^16
    function automatic audio_pkg::sample_t mix_model(
        audio_pkg::sample_t    synth,
        logic [`SRC_WIDTH-1:0] card,
        logic [`SRC_WIDTH-1:0] sprite,
        logic                  spk,
        logic                  spk_en
    );
        int sum;
        sum = int'(synth) + (int'(card) << `SRC_SHIFT) + (int'(sprite) << `SRC_SHIFT);
        if (spk && spk_en) begin
            sum = sum + (1 << `SPK_SHIFT);
        end
        return audio_pkg::sample_t'(sum);  // Keeps the low 16 bits
    endfunction

    function automatic int pick_delay();
        int r;
        r = $random(seed);
        return (r & 32'h7fff_ffff) % (max_ack_delay + 1);
    endfunction

    task automatic check_sample(string name, audio_pkg::sample_t exp, audio_pkg::sample_t act);
        if (act !== exp) begin
            mismatch_cnt++;
            $display("MISMATCH %s: expected %0d (0x%h), actual %0d (0x%h)",
                     name, exp, exp, act, act);
        end
    endtask

    task automatic check_flag(string name, logic exp, logic act);
        if (act !== exp) begin
            mismatch_cnt++;
            $display("MISMATCH %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_count(string name, int exp, int act);
        if (act != exp) begin
            mismatch_cnt++;
            $display("MISMATCH %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic report_failure(string msg);
        fail_cnt++;
        $display("ERROR: %s", msg);
    endtask

    // Sink side of the four-phase handshake, records each sample as req rises
    initial begin : sink_proc
        int wait_cnt;
        bit taken;
        wait_cnt  = 0;
        taken     = 1'b0;
        out_ack_i = 1'b0;
        forever begin
            @(negedge a2bus_if);
            if (!rst_n_i) begin
                out_ack_i = 1'b0;
                taken     = 1'b0;
            end else if (out_ack_i) begin
                if (!out_req_o) begin
                    out_ack_i = 1'b0;  // Req released, finish the handshake
                    taken     = 1'b0;
                end
            end else if (out_req_o) begin
                if (!taken) begin
                    rx_l.push_back(out_l_o);
                    rx_r.push_back(out_r_o);
                    taken    = 1'b1;
                    wait_cnt = pick_delay();
                end
                if (!hold_ack) begin
                    if (wait_cnt == 0) begin
                        out_ack_i = 1'b1;
                    end else begin
                        wait_cnt--;
                    end
                end
            end
        end
    end

    task automatic idle_cycles(int n);
        repeat (n) @(negedge a2bus_if);
    endtask

    task automatic apply_reset();
        @(negedge a2bus_if);
        rst_n_i       = 1'b0;
        sample_tick_i = 1'b0;
        idle_cycles(2);
        exp_l.delete();
        exp_r.delete();
        rx_l.delete();
        rx_r.delete();
        rst_n_i = 1'b1;
    endtask

    // One-cycle tick with the given sources; keep queues the modelled result
    task automatic send_tick(audio_pkg::sample_t sl, audio_pkg::sample_t sr,
                             logic [`SRC_WIDTH-1:0] cl, logic [`SRC_WIDTH-1:0] cr,
                             logic [`SRC_WIDTH-1:0] sp, logic spk, logic en, bit keep);
        @(negedge a2bus_if);
        synth_l_i     = sl;
        synth_r_i     = sr;
        card_l_i      = cl;
        card_r_i      = cr;
        sprite_i      = sp;
        speaker_i     = spk;
        speaker_en_i  = en;
        sample_tick_i = 1'b1;
        if (keep) begin
            exp_l.push_back(mix_model(sl, cl, sp, spk, en));
            exp_r.push_back(mix_model(sr, cr, sp, spk, en));
        end
        @(negedge a2bus_if);
        sample_tick_i = 1'b0;
    endtask

    task automatic wait_rx(string name, int n, int limit);
        int waited;
        waited = 0;
        while (rx_l.size() < n && waited < limit) begin
            @(negedge a2bus_if);
            waited++;
        end
        if (rx_l.size() < n) begin
            report_failure($sformatf("%s: only %0d of %0d samples delivered after %0d cycles",
                                     name, rx_l.size(), n, limit));
        end
    endtask

    task automatic compare_received(string name);
        int idx;
        idx = 0;
        check_count({name, " sample count"}, exp_l.size(), rx_l.size());
        while (exp_l.size() > 0 && rx_l.size() > 0) begin
            check_sample($sformatf("%s left #%0d", name, idx), exp_l.pop_front(), rx_l.pop_front());
            check_sample($sformatf("%s right #%0d", name, idx), exp_r.pop_front(), rx_r.pop_front());
            idx++;
        end
        exp_l.delete();
        exp_r.delete();
        rx_l.delete();
        rx_r.delete();
    endtask

    task automatic test_single_mix();
        int edges;
        max_ack_delay = 0;
        send_tick(16'sd1000, -16'sd2000, 10'd100, 10'd513, 10'd7, 1'b1, 1'b1, 1'b1);
        edges = 1;  // The edge that saw the tick
        while (!out_req_o && edges < 10) begin
            @(negedge a2bus_if);
            edges++;
        end
        check_count("test_single_mix req latency", 3, edges);
        wait_rx("test_single_mix", 1, 20);
        compare_received("test_single_mix");
    endtask

    task automatic test_speaker_enable();
        audio_pkg::sample_t step;
        send_tick(16'sd500, 16'sd500, 10'd20, 10'd30, 10'd5, 1'b1, 1'b0, 1'b1);
        idle_cycles(10);
        send_tick(16'sd500, 16'sd500, 10'd20, 10'd30, 10'd5, 1'b1, 1'b1, 1'b1);
        idle_cycles(10);
        send_tick(16'sd500, 16'sd500, 10'd20, 10'd30, 10'd5, 1'b0, 1'b1, 1'b1);
        wait_rx("test_speaker_enable", 3, 40);
        if (rx_l.size() >= 2) begin
            step = audio_pkg::sample_t'(rx_l[1] - rx_l[0]);
            check_sample("test_speaker_enable step", 16'sd4096, step);
        end
        compare_received("test_speaker_enable");
    endtask

    task automatic test_wraparound();
        send_tick(16'sh7FFF, 16'sh7000, 10'h3FF, 10'h3FF, 10'h3FF, 1'b1, 1'b1, 1'b1);
        idle_cycles(10);
        send_tick(16'sh7FF8, -16'sd1, 10'd0, 10'h3FF, 10'd1, 1'b0, 1'b0, 1'b1);  // Just past +max
        wait_rx("test_wraparound", 2, 40);
        compare_received("test_wraparound");
    endtask

    task automatic test_order_random_ack();
        int                    i;
        int                    r;
        int                    gap;
        audio_pkg::sample_t    sl;
        audio_pkg::sample_t    sr;
        logic [`SRC_WIDTH-1:0] cl;
        logic [`SRC_WIDTH-1:0] cr;
        logic [`SRC_WIDTH-1:0] sp;
        max_ack_delay = 3;
        for (i = 0; i < RAND_TICKS; i++) begin
            r  = $random(seed);
            sl = r[15:0];
            sr = r[31:16];
            r  = $random(seed);
            cl = r[9:0];
            cr = r[19:10];
            sp = r[29:20];
            send_tick(sl, sr, cl, cr, sp, r[30], r[31], 1'b1);
            r   = $random(seed);
            gap = 8 + (r & 3);  // Longer than one handshake, so no backlog
            idle_cycles(gap);
        end
        wait_rx("test_order_random_ack", RAND_TICKS, 100);
        check_flag("test_order_random_ack overflow", 1'b0, overflow_o);
        compare_received("test_order_random_ack");
        max_ack_delay = 0;
    endtask

    task automatic test_overflow();
        int i;
        hold_ack = 1'b1;
        for (i = 0; i < OVF_TICKS; i++) begin
            send_tick(audio_pkg::sample_t'(100 * (i + 1)), audio_pkg::sample_t'(-100 * (i + 1)),
                      10'(i), 10'(2 * i), 10'd3, 1'b0, 1'b0, i < KEPT_TICKS);
            idle_cycles(2);
            if (i == KEPT_TICKS - 1) begin
                check_flag("test_overflow flag before drop", 1'b0, overflow_o);
            end
        end
        check_flag("test_overflow flag", 1'b1, overflow_o);
        check_count("test_overflow delivered while held", 1, rx_l.size());
        hold_ack = 1'b0;
        wait_rx("test_overflow", KEPT_TICKS, 100);
        idle_cycles(30);  // Room for a stray extra sample to show up
        compare_received("test_overflow");
    endtask

    task automatic test_reset_state();
        hold_ack = 1'b1;  // Leave a req open and a sample queued across the reset
        send_tick(16'sd300, -16'sd300, 10'd1, 10'd2, 10'd3, 1'b0, 1'b0, 1'b0);
        idle_cycles(2);
        send_tick(16'sd400, -16'sd400, 10'd4, 10'd5, 10'd6, 1'b0, 1'b0, 1'b0);
        idle_cycles(4);
        check_flag("test_reset_state req before reset", 1'b1, out_req_o);
        apply_reset();
        hold_ack = 1'b0;
        check_flag("test_reset_state req", 1'b0, out_req_o);
        check_flag("test_reset_state overflow", 1'b0, overflow_o);
        idle_cycles(20);
        check_count("test_reset_state delivered", 0, rx_l.size());
        check_flag("test_reset_state req later", 1'b0, out_req_o);
    endtask

    initial begin : watchdog_proc
        #(2 * TEST_CYCLES * CLK_PERIOD);
        $display("Timeout: tests did not finish within %0d ns", 2 * TEST_CYCLES * CLK_PERIOD);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin : main_proc
        seed          = SEED_INIT;
        mismatch_cnt  = 0;
        fail_cnt      = 0;
        hold_ack      = 1'b0;
        max_ack_delay = 0;
        rst_n_i       = 1'b0;
        sample_tick_i = 1'b0;
        synth_l_i     = '0;
        synth_r_i     = '0;
        card_l_i      = '0;
        card_r_i      = '0;
        sprite_i      = '0;
        speaker_i     = 1'b0;
        speaker_en_i  = 1'b0;
        idle_cycles(2);
        rst_n_i = 1'b1;

        test_single_mix();
        test_speaker_enable();
        test_wraparound();
        test_order_random_ack();
        test_overflow();
        test_reset_state();

        $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
        if (mismatch_cnt + fail_cnt == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- audio_top.sv
// Audio path of the card: mixer, sample FIFO and req/ack sender
// Single clock; sample_tick_i is a one-cycle strobe in that domain
// Idle path latency from tick to out_req_o is 3 cycles

`include "audio_defs.svh"

module audio_top (
    input  logic                  a2bus_if,
    input  logic                  rst_n_i,
    input  logic                  sample_tick_i,
    input  audio_pkg::sample_t    synth_l_i,
    input  audio_pkg::sample_t    synth_r_i,
    input  logic [`SRC_WIDTH-1:0] card_l_i,
    input  logic [`SRC_WIDTH-1:0] card_r_i,
    input  logic [`SRC_WIDTH-1:0] sprite_i,
    input  logic                  speaker_i,
    input  logic                  speaker_en_i,
    output audio_pkg::sample_t    out_l_o,
    output audio_pkg::sample_t    out_r_o,
    output logic                  out_req_o,
    input  logic                  out_ack_i,
    output logic                  overflow_o
);

    // Mixer to FIFO
    logic               push;
    audio_pkg::sample_t push_l;
    audio_pkg::sample_t push_r;
    logic               full;

    // FIFO to sender
    logic               empty;
    logic               pop;
    audio_pkg::sample_t head_l;
    audio_pkg::sample_t head_r;

    audio_mixer i_audio_mixer (
        .a2bus_if      (a2bus_if),
        .rst_n_i       (rst_n_i),
        .sample_tick_i (sample_tick_i),
        .synth_l_i     (synth_l_i),
        .synth_r_i     (synth_r_i),
        .card_l_i      (card_l_i),
        .card_r_i      (card_r_i),
        .sprite_i      (sprite_i),
        .speaker_i     (speaker_i),
        .speaker_en_i  (speaker_en_i),
        .full_i        (full),
        .push_o        (push),
        .push_l_o      (push_l),
        .push_r_o      (push_r),
        .overflow_o    (overflow_o)
    );

    sample_fifo i_sample_fifo (
        .a2bus_if (a2bus_if),
        .rst_n_i  (rst_n_i),
        .push_i   (push),
        .push_l_i (push_l),
        .push_r_i (push_r),
        .pop_i    (pop),
        .full_o   (full),
        .empty_o  (empty),
        .head_l_o (head_l),
        .head_r_o (head_r)
    );

    sample_sender i_sample_sender (
        .a2bus_if  (a2bus_if),
        .rst_n_i   (rst_n_i),
        .empty_i   (empty),
        .head_l_i  (head_l),
        .head_r_i  (head_r),
        .pop_o     (pop),
        .out_l_o   (out_l_o),
        .out_r_o   (out_r_o),
        .out_req_o (out_req_o),
        .out_ack_i (out_ack_i)
    );

endmodule

//--- sample_sender.sv
// Four-phase req/ack sender, one sample per handshake
// The entry stays in the FIFO until ack is seen, then is popped
// Sink must drop ack after req falls before the next req can rise

module sample_sender (
    input  logic               a2bus_if,
    input  logic               rst_n_i,
    input  logic               empty_i,
    input  audio_pkg::sample_t head_l_i,
    input  audio_pkg::sample_t head_r_i,
    output logic               pop_o,
    output audio_pkg::sample_t out_l_o,
    output audio_pkg::sample_t out_r_o,
    output logic               out_req_o,
    input  logic               out_ack_i
);

    audio_pkg::send_state_e state;
    logic                   start;

    // Idle and something queued
    assign start = (state == audio_pkg::SEND_IDLE) && !empty_i;

    always_ff @(posedge a2bus_if or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state     <= audio_pkg::SEND_IDLE;
            out_req_o <= 1'b0;
            pop_o     <= 1'b0;
        end else begin
            pop_o <= 1'b0;  // One-cycle strobe
            case (state)
                audio_pkg::SEND_IDLE: begin
                    if (start) begin
                        out_req_o <= 1'b1;
                        state     <= audio_pkg::SEND_REQ;
                    end
                end
                audio_pkg::SEND_REQ: begin
                    if (out_ack_i) begin
                        out_req_o <= 1'b0;
                        pop_o     <= 1'b1;  // Sink has the data, release the entry
                        state     <= audio_pkg::SEND_RELEASE;
                    end
                end
                audio_pkg::SEND_RELEASE: begin
                    if (!out_ack_i) begin
                        state <= audio_pkg::SEND_IDLE;
                    end
                end
                default: begin
                    out_req_o <= 1'b0;
                    state     <= audio_pkg::SEND_IDLE;
                end
            endcase
        end
    end

    // Output data, captured as req goes up
    always_ff @(posedge a2bus_if) begin
        if (start) begin
            out_l_o <= head_l_i;
            out_r_o <= head_r_i;
        end
    end

    // Data held until the sink acknowledges
    a_data_stable : assert property (
        @(posedge a2bus_if) disable iff (!rst_n_i)
        out_req_o && !out_ack_i |=> $stable(out_l_o) && $stable(out_r_o)
    );

    // A new req never rises on top of an old ack
    a_req_after_ack_low : assert property (
        @(posedge a2bus_if) disable iff (!rst_n_i)
        $rose(out_req_o) |-> $past(!out_ack_i)
    );

endmodule

//--- sample_fifo.sv
// Circular buffer of FIFO_DEPTH stereo samples, head shown without a pop
// Push while full is ignored, pop while empty is illegal
// Push and pop in one cycle both take effect when neither empty nor full

`include "audio_defs.svh"

module sample_fifo (
    input  logic               a2bus_if,
    input  logic               rst_n_i,
    input  logic               push_i,
    input  audio_pkg::sample_t push_l_i,
    input  audio_pkg::sample_t push_r_i,
    input  logic               pop_i,
    output logic               full_o,
    output logic               empty_o,
    output audio_pkg::sample_t head_l_o,
    output audio_pkg::sample_t head_r_o
);

    localparam int PTR_W = $clog2(`FIFO_DEPTH);
    localparam int CNT_W = $clog2(`FIFO_DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST_PTR  = PTR_W'(`FIFO_DEPTH - 1);
    localparam logic [CNT_W-1:0] DEPTH_CNT = CNT_W'(`FIFO_DEPTH);

    audio_pkg::sample_t mem_l [`FIFO_DEPTH];
    audio_pkg::sample_t mem_r [`FIFO_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign full_o  = (count == DEPTH_CNT);
    assign empty_o = (count == '0);
    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;

    // Oldest entry
    assign head_l_o = mem_l[rd_ptr];
    assign head_r_o = mem_r[rd_ptr];

    always_ff @(posedge a2bus_if or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // None, or both at once
            endcase
        end
    end

    // Storage
    always_ff @(posedge a2bus_if) begin
        if (do_push) begin
            mem_l[wr_ptr] <= push_l_i;
            mem_r[wr_ptr] <= push_r_i;
        end
    end

    // Sender pops only what it has seen at the head
    a_no_pop_when_empty : assert property (
        @(posedge a2bus_if) disable iff (!rst_n_i)
        !(pop_i && empty_o)
    );

endmodule

//--- audio_mixer.sv
// Sums all sources into one stereo sample per sample_tick_i, no clipping
// A sample that finds the FIFO full is held until there is room; ticks that
// arrive meanwhile are dropped and latch overflow_o until reset

`include "audio_defs.svh"

module audio_mixer (
    input  logic                         a2bus_if,
    input  logic                         rst_n_i,
    input  logic                         sample_tick_i,
    input  audio_pkg::sample_t           synth_l_i,
    input  audio_pkg::sample_t           synth_r_i,
    input  logic [`SRC_WIDTH-1:0]        card_l_i,
    input  logic [`SRC_WIDTH-1:0]        card_r_i,
    input  logic [`SRC_WIDTH-1:0]        sprite_i,
    input  logic                         speaker_i,
    input  logic                         speaker_en_i,
    input  logic                         full_i,
    output logic                         push_o,
    output audio_pkg::sample_t           push_l_o,
    output audio_pkg::sample_t           push_r_o,
    output logic                         overflow_o
);

    localparam int PAD_W = `AUDIO_WIDTH - `SRC_WIDTH - `SRC_SHIFT;

    logic [`AUDIO_WIDTH-1:0] card_l_ext;
    logic [`AUDIO_WIDTH-1:0] card_r_ext;
    logic [`AUDIO_WIDTH-1:0] sprite_ext;
    logic [`AUDIO_WIDTH-1:0] spk_ext;
    audio_pkg::sample_t      mix_l;
    audio_pkg::sample_t      mix_r;
    logic                    valid_r;   // A mixed sample waits in push_l_o/push_r_o
    logic                    stall;     // Held sample blocked by a full FIFO
    logic                    load;

    // Unsigned sources sit at bit SRC_SHIFT, zero padded on top
    assign card_l_ext = {{PAD_W{1'b0}}, card_l_i, {`SRC_SHIFT{1'b0}}};
    assign card_r_ext = {{PAD_W{1'b0}}, card_r_i, {`SRC_SHIFT{1'b0}}};
    assign sprite_ext = {{PAD_W{1'b0}}, sprite_i, {`SRC_SHIFT{1'b0}}};

    // Speaker contributes a fixed step only when enabled
    assign spk_ext = (speaker_i && speaker_en_i) ? (`AUDIO_WIDTH'(1) << `SPK_SHIFT) : '0;

    // Wraps on overflow, as on the card
    assign mix_l = audio_pkg::sample_t'(synth_l_i + card_l_ext + sprite_ext + spk_ext);
    assign mix_r = audio_pkg::sample_t'(synth_r_i + card_r_ext + sprite_ext + spk_ext);

    assign stall  = valid_r && full_i;
    assign load   = sample_tick_i && !stall;
    assign push_o = valid_r && !full_i;

    always_ff @(posedge a2bus_if or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_r    <= 1'b0;
            overflow_o <= 1'b0;
        end else begin
            if (load) begin
                valid_r <= 1'b1;
            end else if (push_o) begin
                valid_r <= 1'b0;
            end
            if (sample_tick_i && stall) begin
                overflow_o <= 1'b1;  // Sticky until reset
            end
        end
    end

    // Sample payload
    always_ff @(posedge a2bus_if) begin
        if (load) begin
            push_l_o <= mix_l;
            push_r_o <= mix_r;
        end
    end

    // FIFO must never see a write while it reports full
    a_no_push_when_full : assert property (
        @(posedge a2bus_if) disable iff (!rst_n_i)
        !(push_o && full_i)
    );

endmodule

//--- audio_pkg.sv
// Types for the audio mixer path
// Widths come from audio_defs.svh

`include "audio_defs.svh"

package audio_pkg;

    // One channel of a mixed sample, two's complement
    typedef logic signed [`AUDIO_WIDTH-1:0] sample_t;

    // Sender handshake phases
    typedef enum logic [1:0] {
        SEND_IDLE    = 2'd0,  // Waiting for a queued sample
        SEND_REQ     = 2'd1,  // Data valid, req high, waiting for ack
        SEND_RELEASE = 2'd2   // req dropped, waiting for ack to fall
    } send_state_e;

endpackage

//--- audio_defs.svh
// Width and depth macros shared by the audio path and its testbench
// The sum wraps modulo 2^AUDIO_WIDTH, so AUDIO_WIDTH must be at least
// SRC_WIDTH + SRC_SHIFT and wider than SPK_SHIFT
`ifndef AUDIO_DEFS_SVH
`define AUDIO_DEFS_SVH

// Mixed stereo sample width, signed
`define AUDIO_WIDTH 16

// Sound card and sprite channels are unsigned
`define SRC_WIDTH 10

// Lifts a 10-bit source into the upper bits of a 13-bit field
`define SRC_SHIFT 3

// Speaker bit lands here, worth 4096
`define SPK_SHIFT 12

// Stereo entries held between mixer and sender
`define FIFO_DEPTH 4

`endif
